/* fixPointPkg.sv */
package fixPointPkg;

	////////////////////////////////////////
	// Q16.16 number format
	////////////////////////////////////////

	// Element width and fraction bits
	localparam int DATA_W = 32;
	localparam int FRAC_W = 16;

	// One signed matrix element
	typedef logic signed [DATA_W-1:0] fixT;

	// Full product of two elements before rescaling
	typedef logic signed [2*DATA_W-1:0] prodT;

	// One quotient bit per step over the shifted dividend
	localparam int DIV_STEPS = DATA_W + FRAC_W;

	// 1.0 in Q16.16
	localparam fixT FIX_ONE = fixT'(1 << FRAC_W);

endpackage

/* matrixPkg.sv */
package matrixPkg;

	// Matrix order and augmented width
	localparam int N = 5;
	localparam int AUG_COLS = 2 * N;

	// Row index and column index into the augmented array
	typedef logic [2:0] rowIdxT;
	typedef logic [3:0] colIdxT;

	// Sequencer states
	typedef enum logic [2:0]
	{
		IDLE,
		PIVOT_READ,
		NORM_DIV,
		NORM_WRITE,
		FACTOR_READ,
		ELIM_STEP,
		ELIM_WRITE,
		FINISH
	} inverterStateT;

endpackage

/* matrixPortIf.sv */
interface matrixPortIf;

	// Element addresses from the sequencer
	matrixPkg::rowIdxT rowA;
	matrixPkg::rowIdxT rowB;
	matrixPkg::colIdxT col;

	// Elements [rowA][col] and [rowB][col]
	fixPointPkg::fixT dataA;
	fixPointPkg::fixT dataB;

	// Write back to [rowA][col]
	logic wrEn;
	fixPointPkg::fixT wrData;

	modport store (input rowA, rowB, col, wrEn, wrData, output dataA, dataB);

	modport seq (output rowA, rowB, col, wrEn, wrData);

	// Arithmetic units only see the read data
	modport unit (input dataA, dataB);

endinterface

/* augmentedMatrix.sv */
module augmentedMatrix (
	input  logic                clk,
	input  logic                rstN,
	input  logic                loadEn,
	input  matrixPkg::rowIdxT   loadRow,
	input  matrixPkg::rowIdxT   loadCol,
	input  fixPointPkg::fixT    loadData,
	input  logic                initIdentity,
	input  matrixPkg::rowIdxT   rdRow,
	input  matrixPkg::rowIdxT   rdCol,
	output fixPointPkg::fixT    rdData,
	matrixPortIf.store          port
);
	import matrixPkg::*;
	import fixPointPkg::*;

	// Left half is the matrix, right half builds up the inverse
	fixT mem [N][AUG_COLS];

	colIdxT rdColAug;

	////////////////////////////////////////
	// Writes
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int r = 0; r < N; r++)
			begin
				for (int c = 0; c < AUG_COLS; c++)
				begin
					mem[r][c] <= '0;
				end
			end
		end
		else
		begin
			// Identity in the right half at start of a run
			if (initIdentity)
			begin
				for (int r = 0; r < N; r++)
				begin
					for (int c = 0; c < N; c++)
					begin
						mem[r][c + N] <= (r == c) ? FIX_ONE : '0;
					end
				end
			end

			// Host load of the left half
			if (loadEn)
			begin
				mem[loadRow][colIdxT'(loadCol)] <= loadData;
			end

			// Sequencer write back
			if (port.wrEn)
			begin
				mem[port.rowA][port.col] <= port.wrData;
			end
		end
	end

	////////////////////////////////////////
	// Reads
	////////////////////////////////////////

	assign port.dataA = mem[port.rowA][port.col];
	assign port.dataB = mem[port.rowB][port.col];

	// Inverse read port is offset into the right half
	assign rdColAug = colIdxT'(rdCol) + colIdxT'(N);
	assign rdData = mem[rdRow][rdColAug];

endmodule

/* rowNormalizer.sv */
module rowNormalizer (
	input  logic                clk,
	input  logic                rstN,
	matrixPortIf.unit           port,
	input  logic                loadPivot,
	output logic                pivotZero,
	input  logic                divStart,
	output fixPointPkg::fixT    quotient,
	output logic                quotientValid
);
	import fixPointPkg::*;

	localparam int CNT_W = $clog2(DIV_STEPS + 1);

	// Magnitude of a signed element
	function automatic logic [DATA_W-1:0] magOf(input fixT v);
		return v[DATA_W-1] ? DATA_W'(-v) : DATA_W'(v);
	endfunction

	fixT pivot;
	logic [DATA_W-1:0] pivotMag;
	logic negResult;

	// Dividend shifts out the top while quotient bits shift in
	logic [DIV_STEPS-1:0] quoReg;
	logic [DATA_W-1:0] remReg;
	logic [DATA_W:0] trial;
	logic [DATA_W:0] trialDiff;
	logic [DATA_W-1:0] quoMag;
	logic [CNT_W-1:0] stepCnt;

	assign pivotZero = (pivot == '0);
	assign pivotMag = magOf(pivot);

	////////////////////////////////////////
	// Step count and valid strobe
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			stepCnt <= '0;
			quotientValid <= 1'b0;
		end
		else
		begin
			quotientValid <= 1'b0;
			if (divStart)
			begin
				stepCnt <= CNT_W'(DIV_STEPS);
			end
			else if (stepCnt != '0)
			begin
				stepCnt <= stepCnt - CNT_W'(1);
				// Last step lands this edge
				if (stepCnt == CNT_W'(1))
				begin
					quotientValid <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Restoring divide datapath
	////////////////////////////////////////

	assign trial = {remReg, quoReg[DIV_STEPS-1]};
	assign trialDiff = trial - {1'b0, pivotMag};

	always_ff @(posedge clk)
	begin
		if (loadPivot)
		begin
			pivot <= port.dataA;
		end

		if (divStart)
		begin
			quoReg <= {magOf(port.dataA), FRAC_W'(0)};
			remReg <= '0;
			negResult <= port.dataA[DATA_W-1] ^ pivot[DATA_W-1];
		end
		else if (stepCnt != '0)
		begin
			// Borrow means the divisor did not fit
			quoReg <= {quoReg[DIV_STEPS-2:0], ~trialDiff[DATA_W]};
			remReg <= trialDiff[DATA_W] ? trial[DATA_W-1:0] : trialDiff[DATA_W-1:0];
		end
	end

	// Sign applied after the magnitude divide, so truncation is toward zero
	assign quoMag = quoReg[DATA_W-1:0];
	assign quotient = negResult ? -fixT'(quoMag) : fixT'(quoMag);

endmodule

/* rowEliminator.sv */
module rowEliminator (
	input  logic                clk,
	input  logic                rstN,
	matrixPortIf.unit           port,
	input  logic                loadFactor,
	output fixPointPkg::fixT    diff
);
	import fixPointPkg::*;

	// Element of the target row in the pivot column
	fixT factor;
	prodT product;
	fixT scaled;

	// Factor times the pivot row element, back to Q16.16
	assign product = prodT'(factor) * prodT'(port.dataB);
	assign scaled = fixT'(product >>> FRAC_W);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			factor <= '0;
			diff <= '0;
		end
		else
		begin
			if (loadFactor)
			begin
				factor <= port.dataA;
			end

			// One element of the row subtraction per cycle
			diff <= port.dataA - scaled;
		end
	end

endmodule

/* gaussJordanCtrl.sv */
module gaussJordanCtrl (
	input  logic                clk,
	input  logic                rstN,
	input  logic                start,
	matrixPortIf.seq            port,
	input  logic                pivotZero,
	input  fixPointPkg::fixT    quotient,
	input  logic                quotientValid,
	input  fixPointPkg::fixT    diff,
	output logic                initIdentity,
	output logic                loadPivot,
	output logic                divStart,
	output logic                loadFactor,
	output logic                busy,
	output logic                done,
	output logic                singular
);
	import matrixPkg::*;

	inverterStateT state;
	rowIdxT pivotRow;
	rowIdxT tgtRow;
	rowIdxT nextRow;
	rowIdxT firstRow;
	colIdxT colCnt;
	logic lastCol;

	assign lastCol = (colCnt == colIdxT'(AUG_COLS - 1));

	// Target rows skip the pivot row
	assign firstRow = (pivotRow == '0) ? rowIdxT'(1) : '0;

	always_comb
	begin
		nextRow = tgtRow + rowIdxT'(1);
		if (nextRow == pivotRow)
		begin
			nextRow = nextRow + rowIdxT'(1);
		end
	end

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			pivotRow <= '0;
			tgtRow <= '0;
			colCnt <= '0;
			singular <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						pivotRow <= '0;
						colCnt <= '0;
						singular <= 1'b0;
						state <= PIVOT_READ;
					end
				end
				PIVOT_READ:
				begin
					state <= NORM_DIV;
				end
				NORM_DIV:
				begin
					// No row swap, a zero pivot ends the run
					if (pivotZero)
					begin
						singular <= 1'b1;
						state <= FINISH;
					end
					else
					begin
						state <= NORM_WRITE;
					end
				end
				NORM_WRITE:
				begin
					// Wait for the quotient, write it in the same cycle
					if (quotientValid)
					begin
						if (lastCol)
						begin
							colCnt <= '0;
							tgtRow <= firstRow;
							state <= FACTOR_READ;
						end
						else
						begin
							colCnt <= colCnt + colIdxT'(1);
							state <= NORM_DIV;
						end
					end
				end
				FACTOR_READ:
				begin
					state <= ELIM_STEP;
				end
				ELIM_STEP:
				begin
					state <= ELIM_WRITE;
				end
				ELIM_WRITE:
				begin
					if (!lastCol)
					begin
						colCnt <= colCnt + colIdxT'(1);
						state <= ELIM_STEP;
					end
					else
					begin
						colCnt <= '0;
						if (nextRow < rowIdxT'(N))
						begin
							tgtRow <= nextRow;
							state <= FACTOR_READ;
						end
						else if (pivotRow == rowIdxT'(N - 1))
						begin
							state <= FINISH;
						end
						else
						begin
							pivotRow <= pivotRow + rowIdxT'(1);
							state <= PIVOT_READ;
						end
					end
				end
				FINISH:
				begin
					state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Strobes and storage addressing
	////////////////////////////////////////

	assign initIdentity = (state == IDLE) && start;
	assign loadPivot = (state == PIVOT_READ);
	assign divStart = (state == NORM_DIV) && !pivotZero;
	assign loadFactor = (state == FACTOR_READ);
	assign busy = (state != IDLE) && (state != FINISH);
	assign done = (state == FINISH);

	assign port.rowA = (state == FACTOR_READ || state == ELIM_STEP || state == ELIM_WRITE)
		? tgtRow : pivotRow;
	assign port.rowB = pivotRow;

	// Pivot column for the pivot and factor reads
	assign port.col = (state == PIVOT_READ || state == FACTOR_READ)
		? colIdxT'(pivotRow) : colCnt;

	assign port.wrEn = ((state == NORM_WRITE) && quotientValid) || (state == ELIM_WRITE);
	assign port.wrData = (state == ELIM_WRITE) ? diff : quotient;

endmodule

/* matrixInverter.sv */
module matrixInverter (
	input  logic                clk,
	input  logic                rstN,
	input  logic                loadEn,
	input  matrixPkg::rowIdxT   loadRow,
	input  matrixPkg::rowIdxT   loadCol,
	input  fixPointPkg::fixT    loadData,
	input  logic                start,
	input  matrixPkg::rowIdxT   rdRow,
	input  matrixPkg::rowIdxT   rdCol,
	output fixPointPkg::fixT    rdData,
	output logic                busy,
	output logic                done,
	output logic                singular
);
	import fixPointPkg::*;

	logic initIdentity;
	logic loadPivot;
	logic pivotZero;
	logic divStart;
	fixT quotient;
	logic quotientValid;
	logic loadFactor;
	fixT diff;

	matrixPortIf matPort ();

	augmentedMatrix uStore (
		.clk          (clk),
		.rstN         (rstN),
		.loadEn       (loadEn),
		.loadRow      (loadRow),
		.loadCol      (loadCol),
		.loadData     (loadData),
		.initIdentity (initIdentity),
		.rdRow        (rdRow),
		.rdCol        (rdCol),
		.rdData       (rdData),
		.port         (matPort.store)
	);

	// Pivot latch and divider
	rowNormalizer uNorm (
		.clk           (clk),
		.rstN          (rstN),
		.port          (matPort.unit),
		.loadPivot     (loadPivot),
		.pivotZero     (pivotZero),
		.divStart      (divStart),
		.quotient      (quotient),
		.quotientValid (quotientValid)
	);

	// Multiply-subtract
	rowEliminator uElim (
		.clk        (clk),
		.rstN       (rstN),
		.port       (matPort.unit),
		.loadFactor (loadFactor),
		.diff       (diff)
	);

	gaussJordanCtrl uCtrl (
		.clk           (clk),
		.rstN          (rstN),
		.start         (start),
		.port          (matPort.seq),
		.pivotZero     (pivotZero),
		.quotient      (quotient),
		.quotientValid (quotientValid),
		.diff          (diff),
		.initIdentity  (initIdentity),
		.loadPivot     (loadPivot),
		.divStart      (divStart),
		.loadFactor    (loadFactor),
		.busy          (busy),
		.done          (done),
		.singular      (singular)
	);

endmodule

/* tbMatrixInverter.sv */
module tbMatrixInverter;
	import fixPointPkg::*;
	import matrixPkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 10;
	localparam int RESET_CYCLES = 3;
	localparam logic [31:0] SEED = 32'h16cafd40;

	// Stimulus file layout
	localparam int NUM_TESTS = 4;
	localparam int ELEMS = N * N;
	localparam int WORDS_PER_TEST = 1 + 2 * ELEMS;

	// Worst case engine run plus load, readback and idle cycles
	localparam int TEST_CYCLES = N * AUG_COLS * (DIV_STEPS + 2)
		+ N * (N - 1) * (1 + 2 * AUG_COLS) + N + 100;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES;

	logic clk = 1'b0;
	logic rstN;
	logic loadEn;
	rowIdxT loadRow;
	rowIdxT loadCol;
	fixT loadData;
	logic start;
	rowIdxT rdRow;
	rowIdxT rdCol;
	fixT rdData;
	logic busy;
	logic done;
	logic singular;

	logic [31:0] stim [NUM_TESTS * WORDS_PER_TEST];

	// Flag left behind by the previous run
	logic lastSingular;

	matrixInverter dut (
		.clk      (clk),
		.rstN     (rstN),
		.loadEn   (loadEn),
		.loadRow  (loadRow),
		.loadCol  (loadCol),
		.loadData (loadData),
		.start    (start),
		.rdRow    (rdRow),
		.rdCol    (rdCol),
		.rdData   (rdData),
		.busy     (busy),
		.done     (done),
		.singular (singular)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Move to just after the next rising edge
	task automatic stepClock();
		@(posedge clk);
		#(DRIVE_DLY);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic string testName(input int t);
		case (t)
			0: return "identity";
			1: return "zero pivot";
			2: return "upper triangular";
			3: return "diagonal";
			default: return "unknown";
		endcase
	endfunction

	task automatic loadMatrix(input int t);
		int base;
		base = t * WORDS_PER_TEST + 1;
		for (int r = 0; r < N; r++)
		begin
			for (int c = 0; c < N; c++)
			begin
				stepClock();
				loadEn = 1'b1;
				loadRow = rowIdxT'(r);
				loadCol = rowIdxT'(c);
				loadData = stim[base + r * N + c];
			end
		end
		stepClock();
		loadEn = 1'b0;
	endtask

	// Start pulse, then watch busy and done until the run ends
	task automatic runEngine(input int t, input logic expSingular);
		string name;
		name = testName(t);
		checkValue({name, " singular held until start"}, 32'(lastSingular), 32'(singular));
		start = 1'b1;
		stepClock();
		start = 1'b0;
		checkValue({name, " busy after start"}, 32'd1, 32'(busy));
		checkValue({name, " singular cleared by start"}, 32'd0, 32'(singular));
		while (done !== 1'b1)
		begin
			checkValue({name, " busy while running"}, 32'd1, 32'(busy));
			stepClock();
		end
		checkValue({name, " busy with done"}, 32'd0, 32'(busy));
		checkValue({name, " singular flag"}, 32'(expSingular), 32'(singular));
		stepClock();
		checkValue({name, " done pulse width"}, 32'd0, 32'(done));
		checkValue({name, " singular after done"}, 32'(expSingular), 32'(singular));
		lastSingular = expSingular;
	endtask

	task automatic readInverse(input int t);
		int base;
		base = t * WORDS_PER_TEST + 1 + ELEMS;
		for (int r = 0; r < N; r++)
		begin
			for (int c = 0; c < N; c++)
			begin
				rdRow = rowIdxT'(r);
				rdCol = rowIdxT'(c);
				// Read port is combinational, sample mid cycle
				#(CLK_PERIOD / 2);
				checkValue($sformatf("%s inverse [%0d][%0d]", testName(t), r, c),
					stim[base + r * N + c], rdData);
				stepClock();
			end
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		int idleCycles;
		logic expSingular;
		rstN = 1'b0;
		loadEn = 1'b0;
		loadRow = '0;
		loadCol = '0;
		loadData = '0;
		start = 1'b0;
		rdRow = '0;
		rdCol = '0;
		lastSingular = 1'b0;
		void'($urandom(SEED));
		$readmemh("matrixInverter_stimulus.txt", stim);

		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DLY);
		rstN = 1'b1;
		checkValue("reset busy", 32'd0, 32'(busy));
		checkValue("reset done", 32'd0, 32'(done));
		checkValue("reset singular", 32'd0, 32'(singular));
		checkValue("reset array", 32'd0, rdData);

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			expSingular = (stim[t * WORDS_PER_TEST] != '0);
			loadMatrix(t);
			runEngine(t, expSingular);
			// Inverse is meaningless after a zero pivot
			if (!expSingular)
			begin
				readInverse(t);
			end
			idleCycles = int'($urandom % 6);
			repeat (idleCycles) stepClock();
		end

		$display("Testbench passed");
		$finish;
	end

	////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////

	initial
	begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("Watchdog expired, done never arrived within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$fatal(1, "Timeout");
	end

endmodule

/* matrixInverter_stimulus.txt */
// Per test: expected singular flag, 25 input words, 25 expected inverse words, row-major
// Elements are signed Q16.16 in hex, five per line
00000000 // identity
00010000 00000000 00000000 00000000 00000000
00000000 00010000 00000000 00000000 00000000
00000000 00000000 00010000 00000000 00000000
00000000 00000000 00000000 00010000 00000000
00000000 00000000 00000000 00000000 00010000
00010000 00000000 00000000 00000000 00000000
00000000 00010000 00000000 00000000 00000000
00000000 00000000 00010000 00000000 00000000
00000000 00000000 00000000 00010000 00000000
00000000 00000000 00000000 00000000 00010000
00000001 // zero at [0][0], inverse not compared
00000000 00010000 00000000 00000000 00000000
00010000 00000000 00000000 00000000 00000000
00000000 00000000 00010000 00000000 00000000
00000000 00000000 00000000 00010000 00000000
00000000 00000000 00000000 00000000 00010000
00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000000 // unit upper triangular, integer inverse
00010000 00020000 00030000 00040000 00050000
00000000 00010000 00020000 00030000 00040000
00000000 00000000 00010000 00020000 00030000
00000000 00000000 00000000 00010000 00020000
00000000 00000000 00000000 00000000 00010000
00010000 FFFE0000 00010000 00000000 00000000
00000000 00010000 FFFE0000 00010000 00000000
00000000 00000000 00010000 FFFE0000 00010000
00000000 00000000 00000000 00010000 FFFE0000
00000000 00000000 00000000 00000000 00010000
00000000 // diagonal 2, 4, 0.5, -1, 8
00020000 00000000 00000000 00000000 00000000
00000000 00040000 00000000 00000000 00000000
00000000 00000000 00008000 00000000 00000000
00000000 00000000 00000000 FFFF0000 00000000
00000000 00000000 00000000 00000000 00080000
00008000 00000000 00000000 00000000 00000000
00000000 00004000 00000000 00000000 00000000
00000000 00000000 00020000 00000000 00000000
00000000 00000000 00000000 FFFF0000 00000000
00000000 00000000 00000000 00000000 00002000

/* compile.f */
fixPointPkg.sv
matrixPkg.sv
matrixPortIf.sv
augmentedMatrix.sv
rowNormalizer.sv
rowEliminator.sv
gaussJordanCtrl.sv
matrixInverter.sv
tbMatrixInverter.sv

/* Makefile */
VERILATOR   := verilator
TOP         := tbMatrixInverter
FILELIST    := compile.f
OBJ_DIR     := obj_dir
LOG         := sim.log
PASS_MSG    := Testbench passed
COMMON_FLAGS := --timing --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS  := --lint-only
BUILD_FLAGS := --binary -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(COMMON_FLAGS)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
